/* memWbPkg.sv */
//------------------------------
// Widths, exec-state encoding, lane and write-request
// structs, and the selective flush range check
//------------------------------
`default_nettype none

package memWbPkg;

    localparam int physRegNumWidth = 6;
    localparam int dataWidth       = 32;
    localparam int alPtrWidth      = 5;
    localparam int mshrNum         = 4;
    localparam int mshrIdWidth     = 2;

    typedef enum logic [1:0] {
        execNotFinished,
        execSuccess,
        execReplay,
        execFault
    } ExecState;

    // One lane leaving the access stage
    typedef struct packed {
        logic                       valid;
        logic                       isLoad;
        logic                       isStore;
        logic                       writeReg;
        logic [physRegNumWidth-1:0] phyDstRegNum;
        logic [dataWidth-1:0]       dataOut;
        logic                       dataValid;
        logic [alPtrWidth-1:0]      activeListPtr;
        ExecState                   execState;
        logic                       hasAllocatedMSHR;
        logic [mshrIdWidth-1:0]     mshrId;
    } MemWbRegPath;

    typedef struct packed {
        logic [physRegNumWidth-1:0] phyDstRegNum;
        logic [dataWidth-1:0]       data;
    } RegWriteReq;

    typedef struct packed {
        logic [alPtrWidth-1:0] ptr;
        ExecState              state;
    } ExecStateWrite;

    typedef struct packed {
        logic                  toRecoveryPhase;
        logic                  flushAllInsns;
        logic [alPtrWidth-1:0] headPtr;
        logic [alPtrWidth-1:0] tailPtr;
    } RecoveryRange;

    // Range is [headPtr, tailPtr) and may wrap around the active list
    function automatic logic alPtrInFlushRange(
        input RecoveryRange          rec,
        input logic [alPtrWidth-1:0] ptr
    );
        logic inRange;
        if (rec.headPtr <= rec.tailPtr) begin
            inRange = (ptr >= rec.headPtr) && (ptr < rec.tailPtr);
        end else begin
            inRange = (ptr >= rec.headPtr) || (ptr < rec.tailPtr);
        end
        return rec.flushAllInsns || (rec.toRecoveryPhase && inRange);
    endfunction

endpackage

`default_nettype wire

/* mshrTracker.sv */
//------------------------------
// MSHR busy bits
// set on allocation, cleared on load release
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module mshrTracker (
    input  logic                             ctrl,
    input  logic                             rst,
    input  logic                             mshrAlloc,
    input  logic [memWbPkg::mshrIdWidth-1:0] mshrAllocId,
    input  logic [memWbPkg::mshrNum-1:0]     mshrRelease,
    output logic [memWbPkg::mshrNum-1:0]     mshrBusy
);
    import memWbPkg::*;

    logic [mshrNum-1:0] allocMask;
    logic [mshrNum-1:0] nextBusy;

    always_comb begin
        for (int j = 0; j < mshrNum; j++) begin
            allocMask[j] = mshrAlloc && (mshrAllocId == mshrIdWidth'(j));
        end
        // Release applied last so it beats a same-cycle allocation
        nextBusy = (mshrBusy | allocMask) & ~mshrRelease;
    end

    always_ff @(posedge ctrl) begin
        if (rst) begin
            mshrBusy <= '0;
        end else begin
            mshrBusy <= nextBusy;
        end
    end

endmodule

`default_nettype wire

/* physRegFile.sv */
//------------------------------
// Physical register file
// one sync write port, one async read port
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module physRegFile (
    input  logic                                ctrl,
    input  logic                                regWe,
    input  memWbPkg::RegWriteReq                regWriteData,
    input  logic [memWbPkg::physRegNumWidth-1:0] regReadNum,
    output logic [memWbPkg::dataWidth-1:0]       regReadData
);
    import memWbPkg::*;

    localparam int regNum = 1 << physRegNumWidth;

    logic [dataWidth-1:0] regArray [regNum];

    always_ff @(posedge ctrl) begin
        if (regWe) begin
            regArray[regWriteData.phyDstRegNum] <= regWriteData.data;
        end
    end

    assign regReadData = regArray[regReadNum];

endmodule

`default_nettype wire

/* execStateTable.sv */
//------------------------------
// Active-list execution state table
// per-lane write ports, one read port
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module execStateTable #(
    parameter int memIssueWidth = 2
) (
    input  logic                                        ctrl,
    input  logic                                        rst,
    input  logic [memIssueWidth-1:0]                    alWrite,
    input  memWbPkg::ExecStateWrite [memIssueWidth-1:0] alWriteData,
    input  logic [memWbPkg::alPtrWidth-1:0]             alReadPtr,
    output memWbPkg::ExecState                          alReadState
);
    import memWbPkg::*;

    localparam int entryNum = 1 << alPtrWidth;

    ExecState stateTable [entryNum];

    // Later lanes in the loop override earlier ones on the same entry
    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int e = 0; e < entryNum; e++) begin
                stateTable[e] <= execNotFinished;
            end
        end else begin
            for (int i = 0; i < memIssueWidth; i++) begin
                if (alWrite[i]) begin
                    stateTable[alWriteData[i].ptr] <= alWriteData[i].state;
                end
            end
        end
    end

    assign alReadState = stateTable[alReadPtr];

endmodule

`default_nettype wire

/* regWriteArbiter.sv */
//------------------------------
// Round-robin arbiter for the single register
// file write port, with conflict flag
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module regWriteArbiter #(
    parameter int memIssueWidth = 2
) (
    input  logic                                     ctrl,
    input  logic                                     rst,
    input  logic [memIssueWidth-1:0]                 req,
    input  memWbPkg::RegWriteReq [memIssueWidth-1:0] reqData,
    output logic [memIssueWidth-1:0]                 grant,
    output logic                                     regConflict,
    output logic                                     regWe,
    output memWbPkg::RegWriteReq                     regWriteData
);
    localparam int ptrWidth = (memIssueWidth > 1) ? $clog2(memIssueWidth) : 1;

    logic [ptrWidth-1:0] rrPtr;
    logic [ptrWidth-1:0] winner;
    logic                found;

    // More than one bit set
    assign regConflict = |(req & (req - 1'b1));

    // Search starts at the round-robin pointer and wraps
    always_comb begin
        int idx;
        found = 1'b0;
        winner = '0;
        for (int k = 0; k < memIssueWidth; k++) begin
            idx = (int'(rrPtr) + k) % memIssueWidth;
            if (!found && req[idx]) begin
                found = 1'b1;
                winner = ptrWidth'(idx);
            end
        end
        grant = '0;
        grant[winner] = found;
    end

    assign regWe = found;
    assign regWriteData = reqData[winner];

    always_ff @(posedge ctrl) begin
        if (rst) begin
            rrPtr <= '0;
        end else if (regConflict) begin
            rrPtr <= (int'(winner) == memIssueWidth - 1) ? '0 : winner + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* memRegWriteStage.sv */
//------------------------------
// Memory register write stage: lane pipeline registers,
// selective flush, active-list update, register write
// requests and MSHR release
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module memRegWriteStage #(
    parameter int memIssueWidth = 2
) (
    input  logic                                        ctrl,
    input  logic                                        rst,
    input  memWbPkg::MemWbRegPath [memIssueWidth-1:0]   prevStage,
    input  logic                                        backEndStall,
    input  logic                                        backEndClear,
    input  memWbPkg::RecoveryRange                      recovery,
    input  logic [memIssueWidth-1:0]                    regGrant,
    input  logic                                        regConflict,
    output logic [memIssueWidth-1:0]                    regReq,
    output memWbPkg::RegWriteReq [memIssueWidth-1:0]    regReqData,
    output logic [memIssueWidth-1:0]                    alWrite,
    output memWbPkg::ExecStateWrite [memIssueWidth-1:0] alWriteData,
    output logic [memWbPkg::mshrNum-1:0]                mshrRelease,
    output logic                                        stageStall
);
    import memWbPkg::*;

    MemWbRegPath [memIssueWidth-1:0] pipeReg;
    logic [memIssueWidth-1:0] done;
    logic [memIssueWidth-1:0] flush;
    logic [memIssueWidth-1:0] update;
    logic [memIssueWidth-1:0] writesReg;
    logic [memIssueWidth-1:0] commit;

    // Held while the back end stalls or a lane waits for the port
    assign stageStall = backEndStall | regConflict;

    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int i = 0; i < memIssueWidth; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stageStall) begin
            pipeReg <= prevStage;
        end
    end

    // Lanes that already committed during a port conflict
    always_ff @(posedge ctrl) begin
        if (rst) begin
            done <= '0;
        end else if (!stageStall) begin
            done <= '0;
        end else begin
            done <= done | commit;
        end
    end

    always_comb begin
        for (int i = 0; i < memIssueWidth; i++) begin
            flush[i] = alPtrInFlushRange(recovery, pipeReg[i].activeListPtr);
            update[i] = pipeReg[i].valid && !backEndStall && !backEndClear &&
                        !flush[i] && !done[i];
            writesReg[i] = pipeReg[i].isLoad && pipeReg[i].writeReg;

            regReq[i] = update[i] && writesReg[i];
            regReqData[i].phyDstRegNum = pipeReg[i].phyDstRegNum;
            regReqData[i].data = pipeReg[i].dataOut;

            // Register writers retire only in their granted cycle
            commit[i] = update[i] && (!writesReg[i] || regGrant[i]);

            alWrite[i] = commit[i];
            alWriteData[i].ptr = pipeReg[i].activeListPtr;
            alWriteData[i].state = commit[i] ? pipeReg[i].execState : execNotFinished;
        end
    end

    // Allocating load frees its MSHR once it retires with data
    always_comb begin
        mshrRelease = '0;
        for (int j = 0; j < mshrNum; j++) begin
            for (int i = 0; i < memIssueWidth; i++) begin
                if (commit[i] && pipeReg[i].isLoad && pipeReg[i].hasAllocatedMSHR &&
                    pipeReg[i].dataValid && pipeReg[i].mshrId == mshrIdWidth'(j)) begin
                    mshrRelease[j] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* memWriteBackUnit.sv */
//------------------------------
// Memory write-back top level: stage, write port
// arbiter, register file, state table, MSHR bits
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module memWriteBackUnit #(
    parameter int memIssueWidth = 2
) (
    input  logic                                      ctrl,
    input  logic                                      rst,
    input  memWbPkg::MemWbRegPath [memIssueWidth-1:0] prevStage,
    input  logic                                      backEndStall,
    input  logic                                      backEndClear,
    input  memWbPkg::RecoveryRange                    recovery,
    input  logic                                      mshrAlloc,
    input  logic [memWbPkg::mshrIdWidth-1:0]          mshrAllocId,
    input  logic [memWbPkg::physRegNumWidth-1:0]      regReadNum,
    input  logic [memWbPkg::alPtrWidth-1:0]           alReadPtr,
    output logic                                      stageStall,
    output logic [memWbPkg::dataWidth-1:0]            regReadData,
    output memWbPkg::ExecState                        alReadState,
    output logic [memWbPkg::mshrNum-1:0]              mshrBusy
);
    import memWbPkg::*;

    logic [memIssueWidth-1:0]          regReq;
    RegWriteReq [memIssueWidth-1:0]    regReqData;
    logic [memIssueWidth-1:0]          regGrant;
    logic                              regConflict;
    logic                              regWe;
    RegWriteReq                        regWriteData;
    logic [memIssueWidth-1:0]          alWrite;
    ExecStateWrite [memIssueWidth-1:0] alWriteData;
    logic [mshrNum-1:0]                mshrRelease;

    memRegWriteStage #(
        .memIssueWidth(memIssueWidth)
    ) stage0 (
        .ctrl(ctrl),
        .rst(rst),
        .prevStage(prevStage),
        .backEndStall(backEndStall),
        .backEndClear(backEndClear),
        .recovery(recovery),
        .regGrant(regGrant),
        .regConflict(regConflict),
        .regReq(regReq),
        .regReqData(regReqData),
        .alWrite(alWrite),
        .alWriteData(alWriteData),
        .mshrRelease(mshrRelease),
        .stageStall(stageStall)
    );

    regWriteArbiter #(
        .memIssueWidth(memIssueWidth)
    ) arbiter0 (
        .ctrl(ctrl),
        .rst(rst),
        .req(regReq),
        .reqData(regReqData),
        .grant(regGrant),
        .regConflict(regConflict),
        .regWe(regWe),
        .regWriteData(regWriteData)
    );

    physRegFile regFile0 (
        .ctrl(ctrl),
        .regWe(regWe),
        .regWriteData(regWriteData),
        .regReadNum(regReadNum),
        .regReadData(regReadData)
    );

    execStateTable #(
        .memIssueWidth(memIssueWidth)
    ) stateTable0 (
        .ctrl(ctrl),
        .rst(rst),
        .alWrite(alWrite),
        .alWriteData(alWriteData),
        .alReadPtr(alReadPtr),
        .alReadState(alReadState)
    );

    mshrTracker mshr0 (
        .ctrl(ctrl),
        .rst(rst),
        .mshrAlloc(mshrAlloc),
        .mshrAllocId(mshrAllocId),
        .mshrRelease(mshrRelease),
        .mshrBusy(mshrBusy)
    );

endmodule

`default_nettype wire

/* memWbChecker.sv */
//------------------------------
// Checker: compares the DUT read ports, busy
// bits and stall level with the model each cycle
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module memWbChecker (
    input  logic                                 ctrl,
    input  logic                                 rst,
    input  logic [memWbPkg::physRegNumWidth-1:0] regReadNum,
    input  logic [memWbPkg::dataWidth-1:0]       regReadData,
    input  memWbPkg::ExecState                   alReadState,
    input  logic [memWbPkg::mshrNum-1:0]         mshrBusy,
    input  logic                                 stageStall,
    input  logic [memWbPkg::dataWidth-1:0]       expRegData,
    input  logic                                 expRegKnown,
    input  memWbPkg::ExecState                   expState,
    input  logic [memWbPkg::mshrNum-1:0]         expBusy,
    input  logic                                 expStall,
    output int                                   errorCount,
    output int                                   checkCount
);
    import memWbPkg::*;

    task automatic compareValue(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    // Sampled mid-cycle, after inputs and the read ports have settled
    always @(negedge ctrl) begin
        if (!rst) begin
            // Never-written registers hold no defined value
            if (expRegKnown) begin
                compareValue($sformatf("regReadData[%0d]", regReadNum),
                             expRegData, regReadData);
            end
            compareValue("alReadState", 32'(expState), 32'(alReadState));
            compareValue("mshrBusy", 32'(expBusy), 32'(mshrBusy));
            compareValue("stageStall", 32'(expStall), 32'(stageStall));
        end
    end

endmodule

`default_nettype wire

/* memWbTb.sv */
//------------------------------
// Testbench top: clock, reset, LFSR stimulus,
// reference model of the state blocks, watchdog
//------------------------------
`default_nettype none
`timescale 1ns/1ps

module memWbTb;
    import memWbPkg::*;

    localparam int laneNum     = 2;
    localparam int stimCycles  = 2000;
    localparam int drainCycles = 10;
    localparam int periodNs    = 100;
    localparam int regCount    = 1 << physRegNumWidth;
    localparam int entryCount  = 1 << alPtrWidth;
    localparam int sweepCycles = 4 + entryCount;

    logic                       ctrl;
    logic                       rst;
    MemWbRegPath [laneNum-1:0]  prevStage;
    logic                       backEndStall;
    logic                       backEndClear;
    RecoveryRange               recovery;
    logic                       mshrAlloc;
    logic [mshrIdWidth-1:0]     mshrAllocId;
    logic [physRegNumWidth-1:0] regReadNum;
    logic [alPtrWidth-1:0]      alReadPtr;
    logic                       stageStall;
    logic [dataWidth-1:0]       regReadData;
    ExecState                   alReadState;
    logic [mshrNum-1:0]         mshrBusy;

    // Reference copy of the architectural state
    logic [dataWidth-1:0]      modelRegs [regCount];
    logic                      modelKnown [regCount] = '{default: 1'b0};
    ExecState                  modelTable [entryCount];
    logic [mshrNum-1:0]        modelBusy;
    MemWbRegPath [laneNum-1:0] modelPipe;
    logic [laneNum-1:0]        modelDone;
    int                        modelRr;
    logic                      lastEdgeStall;

    // What the model expects in the current cycle
    logic [laneNum-1:0] isWriter;
    logic [laneNum-1:0] laneLive;
    logic [laneNum-1:0] laneRetire;
    logic               winFound;
    int                 winLane;
    logic               expConflict;
    logic               expStall;
    logic [mshrNum-1:0] releaseMask;

    logic [dataWidth-1:0] expRegData;
    logic                 expRegKnown;
    ExecState             expState;
    logic [31:0]          lfsrState;
    int                   errorCount;
    int                   checkCount;

    memWriteBackUnit #(
        .memIssueWidth(laneNum)
    ) dut0 (
        .ctrl(ctrl),
        .rst(rst),
        .prevStage(prevStage),
        .backEndStall(backEndStall),
        .backEndClear(backEndClear),
        .recovery(recovery),
        .mshrAlloc(mshrAlloc),
        .mshrAllocId(mshrAllocId),
        .regReadNum(regReadNum),
        .alReadPtr(alReadPtr),
        .stageStall(stageStall),
        .regReadData(regReadData),
        .alReadState(alReadState),
        .mshrBusy(mshrBusy)
    );

    memWbChecker checker0 (
        .ctrl(ctrl),
        .rst(rst),
        .regReadNum(regReadNum),
        .regReadData(regReadData),
        .alReadState(alReadState),
        .mshrBusy(mshrBusy),
        .stageStall(stageStall),
        .expRegData(expRegData),
        .expRegKnown(expRegKnown),
        .expState(expState),
        .expBusy(modelBusy),
        .expStall(expStall),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    assign expRegData  = modelRegs[regReadNum];
    assign expRegKnown = modelKnown[regReadNum];
    assign expState    = modelTable[alReadPtr];

    initial begin
        ctrl = 1'b0;
        forever #(periodNs / 2) ctrl = ~ctrl;
    end

    // Offset from head below the head-to-tail span means inside the window
    function automatic logic ptrFlushed(input RecoveryRange rec, input logic [alPtrWidth-1:0] ptr);
        logic [alPtrWidth-1:0] offset;
        logic [alPtrWidth-1:0] span;
        offset = ptr - rec.headPtr;
        span = rec.tailPtr - rec.headPtr;
        return rec.flushAllInsns || (rec.toRecoveryPhase && (offset < span));
    endfunction

    always_comb begin
        int reqCount;
        int idx;
        reqCount = 0;
        winFound = 1'b0;
        winLane = 0;
        for (int i = 0; i < laneNum; i++) begin
            isWriter[i] = modelPipe[i].isLoad && modelPipe[i].writeReg;
            laneLive[i] = modelPipe[i].valid && !backEndStall && !backEndClear &&
                          !ptrFlushed(recovery, modelPipe[i].activeListPtr) && !modelDone[i];
            if (laneLive[i] && isWriter[i]) begin
                reqCount++;
            end
        end
        // Port goes to the first writer found from the round-robin pointer
        for (int k = 0; k < laneNum; k++) begin
            idx = (modelRr + k) % laneNum;
            if (!winFound && laneLive[idx] && isWriter[idx]) begin
                winFound = 1'b1;
                winLane = idx;
            end
        end
        releaseMask = '0;
        for (int i = 0; i < laneNum; i++) begin
            laneRetire[i] = laneLive[i] && (!isWriter[i] || (winFound && winLane == i));
            if (laneRetire[i] && modelPipe[i].isLoad && modelPipe[i].hasAllocatedMSHR &&
                modelPipe[i].dataValid) begin
                releaseMask[modelPipe[i].mshrId] = 1'b1;
            end
        end
        expConflict = reqCount > 1;
        expStall = backEndStall || expConflict;
    end

    always @(posedge ctrl) begin
        if (rst) begin
            modelPipe <= '0;
            modelDone <= '0;
            modelRr <= 0;
            modelBusy <= '0;
            lastEdgeStall <= 1'b0;
            for (int e = 0; e < entryCount; e++) begin
                modelTable[e] <= execNotFinished;
            end
        end else begin
            if (winFound) begin
                modelRegs[modelPipe[winLane].phyDstRegNum] <= modelPipe[winLane].dataOut;
                modelKnown[modelPipe[winLane].phyDstRegNum] <= 1'b1;
            end
            // Higher lane written last so it wins on a shared pointer
            for (int i = 0; i < laneNum; i++) begin
                if (laneRetire[i]) begin
                    modelTable[modelPipe[i].activeListPtr] <= modelPipe[i].execState;
                end
            end
            // Release beats a same-edge allocation
            for (int j = 0; j < mshrNum; j++) begin
                if (releaseMask[j]) begin
                    modelBusy[j] <= 1'b0;
                end else if (mshrAlloc && int'(mshrAllocId) == j) begin
                    modelBusy[j] <= 1'b1;
                end
            end
            if (expConflict) begin
                modelRr <= (winLane + 1) % laneNum;
            end
            if (!expStall) begin
                modelPipe <= prevStage;
                modelDone <= '0;
            end else begin
                modelDone <= modelDone | laneRetire;
            end
            lastEdgeStall <= expStall;
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    task automatic driveLanes();
        MemWbRegPath lane;
        logic [31:0] r;
        for (int i = 0; i < laneNum; i++) begin
            takeBits(2, r);
            lane.valid = |r[1:0];
            takeBits(1, r);
            lane.isLoad = r[0];
            lane.isStore = !r[0];
            takeBits(1, r);
            lane.writeReg = r[0];
            // Small register range so both lanes often hit the same one
            takeBits(4, r);
            lane.phyDstRegNum = physRegNumWidth'(r[3:0]);
            takeBits(32, r);
            lane.dataOut = r;
            takeBits(1, r);
            lane.dataValid = r[0];
            takeBits(5, r);
            lane.activeListPtr = r[4:0];
            takeBits(2, r);
            lane.execState = ExecState'(r[1:0]);
            takeBits(1, r);
            lane.hasAllocatedMSHR = r[0];
            takeBits(2, r);
            lane.mshrId = r[1:0];
            prevStage[i] = lane;
        end
    endtask

    task automatic driveControls();
        logic [31:0] r;
        takeBits(3, r);
        backEndStall = (r[2:0] == 3'd0);
        takeBits(4, r);
        backEndClear = (r[3:0] == 4'd0);
        takeBits(3, r);
        recovery.toRecoveryPhase = (r[2:0] == 3'd0);
        takeBits(5, r);
        recovery.flushAllInsns = (r[4:0] == 5'd0);
        takeBits(5, r);
        recovery.headPtr = r[4:0];
        takeBits(5, r);
        recovery.tailPtr = r[4:0];
        takeBits(1, r);
        mshrAlloc = r[0];
        takeBits(2, r);
        mshrAllocId = r[1:0];
        takeBits(4, r);
        regReadNum = physRegNumWidth'(r[3:0]);
        takeBits(5, r);
        alReadPtr = r[4:0];
    endtask

    initial begin
        lfsrState = 32'h5b06;
        rst = 1'b1;
        prevStage = '0;
        backEndStall = 1'b0;
        backEndClear = 1'b0;
        recovery = '0;
        mshrAlloc = 1'b0;
        mshrAllocId = '0;
        regReadNum = '0;
        alReadPtr = '0;
        repeat (3) @(posedge ctrl);
        #5 rst = 1'b0;

        for (int c = 0; c < stimCycles; c++) begin
            @(posedge ctrl);
            #5;
            driveControls();
            if (!lastEdgeStall) begin
                driveLanes();
            end
        end

        // Let held lanes drain with quiet controls
        for (int c = 0; c < drainCycles; c++) begin
            @(posedge ctrl);
            #5;
            backEndStall = 1'b0;
            backEndClear = 1'b0;
            recovery = '0;
            mshrAlloc = 1'b0;
            if (!lastEdgeStall) begin
                prevStage = '0;
            end
        end

        // Second reset over populated state and a sweep of every entry
        @(posedge ctrl);
        #5 rst = 1'b1;
        repeat (3) @(posedge ctrl);
        #5 rst = 1'b0;
        for (int e = 0; e < entryCount; e++) begin
            @(posedge ctrl);
            #5;
            alReadPtr = alPtrWidth'(e);
        end

        @(negedge ctrl);
        #1;
        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(2 * (stimCycles + drainCycles + sweepCycles + 3) * periodNs);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
memWbPkg.sv
mshrTracker.sv
physRegFile.sv
execStateTable.sv
regWriteArbiter.sv
memRegWriteStage.sv
memWriteBackUnit.sv
memWbChecker.sv
memWbTb.sv

/* Makefile */
# Verilator simulation of the memory write-back unit

VERILATOR ?= verilator
TOP       ?= memWbTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
